// ==== npc.f ====
npc_pkg.sv
npc_decoder.sv
npc_regfile.sv
npc_execute.sv
npc_bus_ctrl.sv
npc.sv
npc_assert.sv
npc_checker.sv
tb_npc.sv

// ==== Bender.yml ====
package:
  name: npc

sources:
  - npc_pkg.sv
  - npc_decoder.sv
  - npc_regfile.sv
  - npc_execute.sv
  - npc_bus_ctrl.sv
  - npc.sv
  - target: simulation
    files:
      - npc_assert.sv
      - npc_checker.sv
      - tb_npc.sv

// ==== tb_npc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_npc;

    logic        clk;
    logic        reset;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [2:0]  arprot;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_inst;
    logic [4:0]  retire_rd;
    logic        retire_wen;
    logic [31:0] retire_wdata;
    logic        halted;
    logic        bus_error;

    logic [31:0] prog [0:255];
    logic [31:0] lfsr;
    logic        err_on;
    logic [31:0] err_addr;
    int          delays;
    int          proto_errs;

    npc #(
        .RESET_PC (32'h0)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .arprot       (arprot),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_rd    (retire_rd),
        .retire_wen   (retire_wen),
        .retire_wdata (retire_wdata),
        .halted       (halted),
        .bus_error    (bus_error)
    );

    npc_checker #(
        .RESET_PC (32'h0)
    ) chk_i (
        .clk          (clk),
        .reset        (reset),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_rd    (retire_rd),
        .retire_wen   (retire_wen),
        .retire_wdata (retire_wdata)
    );

    always #4 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] addr_hash(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e37_79b1;
        return h ^ (h >> 15) ^ 32'h5a5a_c3c3;
    endfunction

    // program below 1 KB, hashed data everywhere else
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (addr < 32'd1024) begin
            return prog[addr[9:2]];
        end
        return addr_hash(addr);
    endfunction

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act, inout int errors);
        if (exp !== act) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic build_program();
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic [31:0] skip;
        logic [31:0] off;
        int          t;
        // every register gets a known value first
        for (int i = 1; i < 32; i++) begin
            take_bits(12, imm);
            prog[i - 1] = {imm[11:0], 5'd0, 3'b000, i[4:0], npc_pkg::OPC_OPIMM};
        end
        for (int i = 31; i < 255; i++) begin
            take_bits(3, kind);
            take_bits(5, rd);
            take_bits(5, rs1);
            take_bits(5, rs2);
            take_bits(20, imm);
            // jumps only go forward so the run always ends
            take_bits(3, skip);
            t   = (i + 1 + skip > 255) ? 255 : i + 1 + skip;
            off = (t - i) * 4;
            case (kind[2:0])
                3'd0: prog[i] = {imm[19:0], rd[4:0], npc_pkg::OPC_LUI};
                3'd1: prog[i] = {imm[19:0], rd[4:0], npc_pkg::OPC_AUIPC};
                3'd2: prog[i] = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], npc_pkg::OPC_OPIMM};
                3'd3: prog[i] = {7'd0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], npc_pkg::OPC_OP};
                3'd4: prog[i] = {off[20], off[10:1], off[11], off[19:12], rd[4:0],
                                 npc_pkg::OPC_JAL};
                3'd5: prog[i] = {t[9:0], 2'b00, 5'd0, 3'b000, rd[4:0], npc_pkg::OPC_JALR};
                3'd6: prog[i] = {imm[11:0], imm[12] ? rs1[4:0] : 5'd0, 3'b010, rd[4:0],
                                 npc_pkg::OPC_LOAD};
                default: prog[i] = {imm[19:0], rd[4:0], 7'b0101011};
            endcase
        end
        prog[255] = npc_pkg::EBREAK_WORD;
    endtask

    // AXI4-Lite read slave with 0 to 3 cycles on each channel
    initial begin : slave
        int          st;
        logic [31:0] cnt;
        logic [31:0] addr;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = 32'd0;
        rresp   = 2'b00;
        st      = 0;
        cnt     = 32'd0;
        addr    = 32'd0;
        forever begin
            @(posedge clk);
            #1;
            if (reset) begin
                arready = 1'b0;
                rvalid  = 1'b0;
                st      = 0;
            end else begin
                case (st)
                    0: if (arvalid) begin
                        take_bits(2, cnt);
                        delays += (cnt != 0);
                        st = 1;
                    end
                    1: if (cnt == 0) begin
                        arready = 1'b1;
                        addr    = araddr;
                        expect_value("arprot", 32'd0, arprot, proto_errs);
                        st      = 2;
                    end else begin
                        cnt--;
                    end
                    2: begin
                        arready = 1'b0;
                        take_bits(2, cnt);
                        delays += (cnt != 0);
                        st = 3;
                    end
                    3: if (cnt == 0) begin
                        // the master waits for this response
                        expect_value("rready", 32'd1, rready, proto_errs);
                        rvalid = 1'b1;
                        rdata  = mem_word(addr);
                        rresp  = (err_on && addr == err_addr) ? 2'b10 : 2'b00;
                        st     = 4;
                    end else begin
                        cnt--;
                    end
                    default: begin
                        rvalid = 1'b0;
                        st     = 0;
                    end
                endcase
            end
        end
    end

    task automatic wait_halt(input string what, output bit ok);
        int n;
        n = 0;
        while (halted !== 1'b1 && n < 40000) begin
            @(posedge clk);
            #1;
            n++;
        end
        ok = (halted === 1'b1);
        if (!ok) begin
            $display("TIMEOUT: halted never rose while waiting for %s", what);
        end
    endtask

    task automatic show_result(input string name, input int errors, inout int passed,
                               inout int failed);
        if (errors == 0) begin
            $display("%s: PASS", name);
            passed++;
        end else begin
            $display("%s: FAIL (%0d errors)", name, errors);
            failed++;
        end
    endtask

    initial begin
        int errors;
        int passed;
        int failed;
        int p;
        int f;
        int n;
        bit ok;
        clk        = 1'b0;
        reset      = 1'b1;
        err_on     = 1'b0;
        err_addr   = 32'd124;
        lfsr       = 32'h876c16f5;
        delays     = 0;
        proto_errs = 0;
        passed     = 0;
        failed     = 0;
        build_program();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        errors = 0;
        expect_value("arvalid", 32'd0, arvalid, errors);
        expect_value("retire_valid", 32'd0, retire_valid, errors);
        expect_value("halted", 32'd0, halted, errors);
        n = 0;
        while (arvalid !== 1'b1 && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (arvalid !== 1'b1) begin
            $display("TIMEOUT: first arvalid never appeared");
            errors++;
        end else begin
            expect_value("araddr", 32'd0, araddr, errors);
        end
        show_result("test 1 reset state and first fetch", errors, passed, failed);

        wait_halt("ebreak of the first run", ok);
        chk_i.report(p, f);
        passed += p;
        failed += f;

        errors = ok ? 0 : 1;
        expect_value("last retire_inst", npc_pkg::EBREAK_WORD, chk_i.last_inst, errors);
        expect_value("bus_error", 32'd0, bus_error, errors);
        repeat (20) begin
            @(posedge clk);
            #1;
            expect_value("arvalid", 32'd0, arvalid, errors);
            expect_value("halted", 32'd1, halted, errors);
        end
        // second run stops on the error response of word 31
        reset  = 1'b1;
        err_on = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        wait_halt("the error response", ok);
        if (!ok) begin
            errors++;
        end else begin
            expect_value("bus_error", 32'd1, bus_error, errors);
        end
        expect_value("commits before error", 32'd31, chk_i.run_commits, errors);
        show_result("test 5 ebreak halt and bus error", errors, passed, failed);

        errors = chk_i.mismatches + proto_errs;
        if (delays == 0) begin
            $display("test 6: the slave never inserted a delay");
            errors++;
        end
        show_result("test 6 commits under random delays", errors, passed, failed);

        $display("tests passed %0d, failed %0d, commits %0d, assertion failures %0d",
                 passed, failed, chk_i.total_commits, dut_i.assert_i.failures);
        if (failed == 0 && dut_i.assert_i.failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== npc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_checker #(
    parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
    input logic        clk,
    input logic        reset,
    input logic        retire_valid,
    input logic [31:0] retire_pc,
    input logic [31:0] retire_inst,
    input logic [4:0]  retire_rd,
    input logic        retire_wen,
    input logic [31:0] retire_wdata
);

    logic [31:0] regs [0:31];
    logic [31:0] model_pc;
    logic [31:0] last_inst;
    int          errs [2:4];
    int          seen [2:4];
    int          prev_cat;
    int          run_commits;
    int          total_commits;
    int          mismatches;

    initial begin
        for (int i = 2; i <= 4; i++) begin
            errs[i] = 0;
            seen[i] = 0;
        end
        total_commits = 0;
        mismatches    = 0;
    end

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act, input int cat);
        if (exp !== act) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp, act);
            errs[cat]++;
            mismatches++;
        end
    endtask

    // 2 arithmetic, 3 jumps, 4 loads and unknown words
    always @(negedge clk) begin
        logic [31:0] inst;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] imm_i;
        logic [31:0] imm_j;
        logic [31:0] wdata;
        logic [31:0] nxt;
        logic [4:0]  rd;
        logic        wen;
        int          cat;
        if (reset) begin
            model_pc    = RESET_PC;
            prev_cat    = 2;
            run_commits = 0;
            for (int i = 0; i < 32; i++) begin
                regs[i] = 32'd0;
            end
        end else if (retire_valid) begin
            inst  = tb_npc.mem_word(model_pc);
            rd    = inst[11:7];
            s1    = regs[inst[19:15]];
            s2    = regs[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            wen   = 1'b1;
            wdata = 32'd0;
            nxt   = model_pc + 32'd4;
            cat   = 2;
            if (inst[6:0] == npc_pkg::OPC_LUI) begin
                wdata = {inst[31:12], 12'h000};
            end else if (inst[6:0] == npc_pkg::OPC_AUIPC) begin
                wdata = model_pc + {inst[31:12], 12'h000};
            end else if (inst[6:0] == npc_pkg::OPC_JAL) begin
                wdata = model_pc + 32'd4;
                nxt   = model_pc + imm_j;
                cat   = 3;
            end else if (inst[6:0] == npc_pkg::OPC_JALR && inst[14:12] == 3'b000) begin
                wdata = model_pc + 32'd4;
                nxt   = (s1 + imm_i) & ~32'd1;
                cat   = 3;
            end else if (inst[6:0] == npc_pkg::OPC_OPIMM && inst[14:12] == 3'b000) begin
                wdata = s1 + imm_i;
            end else if (inst[6:0] == npc_pkg::OPC_OP && inst[14:12] == 3'b000) begin
                wdata = s1 + s2;
            end else if (inst[6:0] == npc_pkg::OPC_LOAD && inst[14:12] == 3'b010) begin
                wdata = tb_npc.mem_word((s1 + imm_i) & ~32'd3);
                cat   = 4;
            end else begin
                // ebreak and unknown words write nothing
                wen = 1'b0;
                cat = 4;
            end
            // a wrong pc is blamed on the instruction that chose it
            compare_field("retire_pc", model_pc, retire_pc, prev_cat);
            compare_field("retire_inst", inst, retire_inst, cat);
            compare_field("retire_rd", {27'd0, rd}, {27'd0, retire_rd}, cat);
            compare_field("retire_wen", {31'd0, wen}, {31'd0, retire_wen}, cat);
            if (wen) begin
                compare_field("retire_wdata", wdata, retire_wdata, cat);
            end
            if (wen && rd != 5'd0) begin
                regs[rd] = wdata;
            end
            model_pc  = nxt;
            prev_cat  = cat;
            last_inst = inst;
            seen[cat]++;
            run_commits++;
            total_commits++;
        end
    end

    task automatic report(output int passed, output int failed);
        string names [2:4];
        names[2] = "test 2 lui auipc addi add commits";
        names[3] = "test 3 jal jalr link and redirect";
        names[4] = "test 4 lw data and unknown words";
        passed = 0;
        failed = 0;
        for (int i = 2; i <= 4; i++) begin
            if (errs[i] == 0 && seen[i] > 0) begin
                $display("%s: PASS (%0d commits)", names[i], seen[i]);
                passed++;
            end else begin
                $display("%s: FAIL (%0d errors, %0d commits)", names[i], errs[i], seen[i]);
                failed++;
            end
        end
    endtask

endmodule

`default_nettype wire

// ==== npc_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_assert (
    input logic        clk,
    input logic        reset,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        rvalid,
    input logic        rready,
    input logic        retire_valid,
    input logic        halted
);

    logic outstanding;
    int   failures;

    initial failures = 0;

    // set by an address transfer, cleared by its response
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (arvalid && arready) begin
            outstanding <= 1'b1;
        end else if (rvalid && rready) begin
            outstanding <= 1'b0;
        end
    end

    ar_stable: assert property (@(posedge clk) disable iff (reset)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
    else begin
        failures++;
        $error("arvalid or araddr changed before arready");
    end

    one_read: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> !arvalid)
    else begin
        failures++;
        $error("second read issued while one is outstanding");
    end

    no_retire_halted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !retire_valid)
    else begin
        failures++;
        $error("retire_valid high while halted");
    end

endmodule

bind npc npc_assert assert_i (
    .clk          (clk),
    .reset        (reset),
    .arvalid      (arvalid),
    .arready      (arready),
    .araddr       (araddr),
    .rvalid       (rvalid),
    .rready       (rready),
    .retire_valid (retire_valid),
    .halted       (halted)
);

`default_nettype wire

// ==== npc.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc #(
    parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    output logic [2:0]  arprot,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    output logic        rready,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_inst,
    output logic [4:0]  retire_rd,
    output logic        retire_wen,
    output logic [31:0] retire_wdata,
    output logic        halted,
    output logic        bus_error
);

    logic [31:0]      inst;
    logic [31:0]      pc;
    logic [31:0]      load_data;
    npc_pkg::exe_op_t op;
    logic [31:0]      imm;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic             reg_wen;
    logic             is_load;
    logic             is_halt;
    logic [31:0]      src1;
    logic [31:0]      src2;
    logic [31:0]      result;
    logic [31:0]      next_pc;
    logic [31:0]      load_addr;
    logic             rf_wen;
    logic [4:0]       rf_waddr;
    logic [31:0]      rf_wdata;

    // unprivileged, secure, data access
    assign arprot = 3'b000;

    npc_bus_ctrl #(
        .RESET_PC (RESET_PC)
    ) bus_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .is_load      (is_load),
        .is_halt      (is_halt),
        .reg_wen      (reg_wen),
        .rd           (rd),
        .result       (result),
        .next_pc      (next_pc),
        .load_addr    (load_addr),
        .inst         (inst),
        .pc           (pc),
        .load_data    (load_data),
        .rf_wen       (rf_wen),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_rd    (retire_rd),
        .retire_wen   (retire_wen),
        .retire_wdata (retire_wdata),
        .halted       (halted),
        .bus_error    (bus_error)
    );

    npc_decoder decoder_i (
        .inst    (inst),
        .op      (op),
        .imm     (imm),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .reg_wen (reg_wen),
        .is_load (is_load),
        .is_halt (is_halt)
    );

    npc_regfile regfile_i (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (src1),
        .rdata2 (src2),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    npc_execute execute_i (
        .op        (op),
        .imm       (imm),
        .src1      (src1),
        .src2      (src2),
        .pc        (pc),
        .load_data (load_data),
        .result    (result),
        .next_pc   (next_pc),
        .load_addr (load_addr)
    );

endmodule

`default_nettype wire

// ==== npc_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_bus_ctrl #(
    parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    output logic        rready,
    input  logic        is_load,
    input  logic        is_halt,
    input  logic        reg_wen,
    input  logic [4:0]  rd,
    input  logic [31:0] result,
    input  logic [31:0] next_pc,
    input  logic [31:0] load_addr,
    output logic [31:0] inst,
    output logic [31:0] pc,
    output logic [31:0] load_data,
    output logic        rf_wen,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_inst,
    output logic [4:0]  retire_rd,
    output logic        retire_wen,
    output logic [31:0] retire_wdata,
    output logic        halted,
    output logic        bus_error
);

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        DECODE,
        LOAD,
        LOAD_WAIT,
        RETIRE,
        HALT
    } state_t;

    state_t state;

    // a response is only awaited after the address went out
    assign rready       = (state == FETCH_WAIT) || (state == LOAD_WAIT);
    assign retire_valid = (state == RETIRE);

    assign rf_wen   = retire_valid && reg_wen;
    assign rf_waddr = rd;
    assign rf_wdata = result;

    assign retire_pc    = pc;
    assign retire_inst  = inst;
    assign retire_rd    = rd;
    assign retire_wen   = reg_wen;
    assign retire_wdata = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH;
            pc        <= RESET_PC;
            arvalid   <= 1'b0;
            araddr    <= RESET_PC;
            halted    <= 1'b0;
            bus_error <= 1'b0;
        end else begin
            case (state)
                // address phase, arvalid held until accepted
                FETCH, LOAD: begin
                    if (!arvalid) begin
                        arvalid <= 1'b1;
                        araddr  <= (state == FETCH) ? pc : load_addr;
                    end else if (arready) begin
                        arvalid <= 1'b0;
                        state   <= (state == FETCH) ? FETCH_WAIT : LOAD_WAIT;
                    end
                end
                FETCH_WAIT, LOAD_WAIT: begin
                    if (rvalid) begin
                        if (rresp != 2'b00) begin
                            bus_error <= 1'b1;
                            halted    <= 1'b1;
                            state     <= HALT;
                        end else begin
                            state <= (state == FETCH_WAIT) ? DECODE : RETIRE;
                        end
                    end
                end
                DECODE: state <= is_load ? LOAD : RETIRE;
                RETIRE: begin
                    pc <= next_pc;
                    if (is_halt) begin
                        halted <= 1'b1;
                        state  <= HALT;
                    end else begin
                        state <= FETCH;
                    end
                end
                default: state <= HALT;
            endcase
        end
    end

    // payload registers, captured on a good response
    always_ff @(posedge clk) begin
        if (rvalid && rready && (rresp == 2'b00)) begin
            if (state == FETCH_WAIT) begin
                inst <= rdata;
            end else begin
                load_data <= rdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== npc_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_execute (
    input  npc_pkg::exe_op_t op,
    input  logic [31:0]      imm,
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    input  logic [31:0]      pc,
    input  logic [31:0]      load_data,
    output logic [31:0]      result,
    output logic [31:0]      next_pc,
    output logic [31:0]      load_addr
);

    logic [31:0] seq_pc;
    logic [31:0] pc_imm;
    logic [31:0] src1_imm;

    assign seq_pc   = pc + 32'd4;
    assign pc_imm   = pc + imm;
    assign src1_imm = src1 + imm;

    // word aligned, low two bits dropped
    assign load_addr = {src1_imm[31:2], 2'b00};

    // write-back value
    always_comb begin
        case (op)
            npc_pkg::EXE_LUI:   result = imm;
            npc_pkg::EXE_AUIPC: result = pc_imm;
            npc_pkg::EXE_JAL:   result = seq_pc;
            npc_pkg::EXE_JALR:  result = seq_pc;
            npc_pkg::EXE_ADDI:  result = src1_imm;
            npc_pkg::EXE_ADD:   result = src1 + src2;
            npc_pkg::EXE_LW:    result = load_data;
            default:            result = 32'd0;
        endcase
    end

    // redirect for jumps, otherwise fall through
    always_comb begin
        case (op)
            npc_pkg::EXE_JAL:  next_pc = pc_imm;
            npc_pkg::EXE_JALR: next_pc = {src1_imm[31:1], 1'b0};
            default:           next_pc = seq_pc;
        endcase
    end

endmodule

`default_nettype wire

// ==== npc_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [0:31];

    // x0 reads as zero, entry 0 is never written
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

    // no writes while the core is held in reset
    always_ff @(posedge clk) begin
        if (wen && !reset && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== npc_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_decoder (
    input  logic [31:0]      inst,
    output npc_pkg::exe_op_t op,
    output logic [31:0]      imm,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [4:0]       rd,
    output logic             reg_wen,
    output logic             is_load,
    output logic             is_halt
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    // immediate formats, all sign extended
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        op      = npc_pkg::EXE_NOP;
        imm     = imm_i;
        reg_wen = 1'b0;
        is_load = 1'b0;
        is_halt = 1'b0;
        case (opcode)
            npc_pkg::OPC_LUI: begin
                op      = npc_pkg::EXE_LUI;
                imm     = imm_u;
                reg_wen = 1'b1;
            end
            npc_pkg::OPC_AUIPC: begin
                op      = npc_pkg::EXE_AUIPC;
                imm     = imm_u;
                reg_wen = 1'b1;
            end
            npc_pkg::OPC_JAL: begin
                op      = npc_pkg::EXE_JAL;
                imm     = imm_j;
                reg_wen = 1'b1;
            end
            npc_pkg::OPC_JALR: begin
                op      = (funct3 == npc_pkg::F3_ADD) ? npc_pkg::EXE_JALR : npc_pkg::EXE_NOP;
                reg_wen = (funct3 == npc_pkg::F3_ADD);
            end
            npc_pkg::OPC_OPIMM: begin
                op      = (funct3 == npc_pkg::F3_ADD) ? npc_pkg::EXE_ADDI : npc_pkg::EXE_NOP;
                reg_wen = (funct3 == npc_pkg::F3_ADD);
            end
            npc_pkg::OPC_OP: begin
                op      = (funct3 == npc_pkg::F3_ADD) ? npc_pkg::EXE_ADD : npc_pkg::EXE_NOP;
                reg_wen = (funct3 == npc_pkg::F3_ADD);
            end
            npc_pkg::OPC_LOAD: begin
                op      = (funct3 == npc_pkg::F3_LW) ? npc_pkg::EXE_LW : npc_pkg::EXE_NOP;
                reg_wen = (funct3 == npc_pkg::F3_LW);
                is_load = (funct3 == npc_pkg::F3_LW);
            end
            // ebreak only, other system words fall through as no-ops
            npc_pkg::OPC_SYSTEM: is_halt = (inst == npc_pkg::EBREAK_WORD);
            default: op = npc_pkg::EXE_NOP;
        endcase
    end

endmodule

`default_nettype wire

// ==== npc_pkg.sv ====
`default_nettype none

package npc_pkg;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 for add/addi/jalr and for lw
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_LW  = 3'b010;

    // the only SYSTEM word that does anything
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // operation selected by the decoder, consumed by execute
    typedef enum logic [2:0] {
        EXE_NOP,
        EXE_LUI,
        EXE_AUIPC,
        EXE_JAL,
        EXE_JALR,
        EXE_ADDI,
        EXE_ADD,
        EXE_LW
    } exe_op_t;

endpackage

`default_nettype wire
